//--- flist.f
hw/axi_mem_pkg.sv
hw/mem_array.sv
hw/axi_mem_write_ctrl.sv
hw/axi_mem_read_ctrl.sv
hw/axi_mem_top.sv
verification/axi_mem_props.sv
verification/tb_axi_mem.sv

//--- hw/axi_mem_pkg.sv
// Shared widths, depth, response codes and channel payloads for the burst memory
// Addresses count words, not bytes. Depth must stay a power of two for MEM_AW
// len fields carry the beat count minus one, as on AXI
package axi_mem_pkg;

	localparam int ADDR_W    = 32;   // Word address width
	localparam int DATA_W    = 32;   // One word per beat
	localparam int MEM_WORDS = 1024; // Memory depth in words
	localparam int MEM_AW    = $clog2(MEM_WORDS); // 10 bit index
	localparam int LEN_W     = 8;    // Up to 256 beats

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Address request, shared by aw and ar
	typedef struct packed {
		logic [ADDR_W-1:0] addr; // Start word address
		logic [LEN_W-1:0]  len;  // Beats minus one
	} addr_req_t;

	// Write data beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last; // Final beat of the burst
	} w_beat_t;

	// Read data beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp; // Per-beat status
		logic              last;
	} r_beat_t;

	// Memory write port
	typedef struct packed {
		logic              en;
		logic [MEM_AW-1:0] idx;
		logic [DATA_W-1:0] data;
	} mem_wr_t;

endpackage

//--- hw/axi_mem_read_ctrl.sv
// Read channel controller, one burst at a time, incrementing addresses only
// Every beat takes fetch, capture and present, so a beat appears 2 cycles
// after the ar transfer or the previous r transfer
// Out of range beats return zero data with SLVERR
`timescale 1ns/1ps

module axi_mem_read_ctrl import axi_mem_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	// Read address channel
	input  addr_req_t         ar,
	input  logic              ar_valid,
	output logic              ar_ready,
	// Read data channel
	output r_beat_t           r,
	output logic              r_valid,
	input  logic              r_ready,
	// Memory read port
	output logic              rd_en,
	output logic [MEM_AW-1:0] rd_idx,
	input  logic [DATA_W-1:0] rd_data
);

	typedef enum logic [1:0] {
		ST_IDLE,    // Waiting for ar
		ST_FETCH,   // Memory read issued
		ST_CAPTURE, // rd_data valid this cycle
		ST_PRESENT  // Beat on the bus
	} rd_state_t;

	rd_state_t         state;
	logic [ADDR_W-1:0] cur_addr;  // Word address of the current beat
	logic [LEN_W-1:0]  beat_cnt;
	logic [LEN_W-1:0]  burst_len;
	logic              in_range;
	logic              last_beat;
	logic              ar_fire;
	logic              r_fire;

	assign ar_fire   = ar_valid && ar_ready;
	assign r_fire    = r_valid && r_ready;

	assign in_range  = (cur_addr < ADDR_W'(MEM_WORDS));
	assign last_beat = (beat_cnt == burst_len);

	// Only in-range words reach the memory
	assign rd_en     = (state == ST_FETCH) && in_range;
	assign rd_idx    = cur_addr[MEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (ar_fire) begin
					cur_addr  <= ar.addr;
					burst_len <= ar.len;
					beat_cnt  <= '0;
					ar_ready  <= 1'b0;
					state     <= ST_FETCH;
				end else begin
					ar_ready  <= 1'b1;
				end
			end
			ST_FETCH: state <= ST_CAPTURE; // Memory registers the word
			ST_CAPTURE: begin
				r.data  <= in_range ? rd_data : '0;
				r.resp  <= in_range ? RESP_OKAY : RESP_SLVERR;
				r.last  <= last_beat;
				r_valid <= 1'b1;
				state   <= ST_PRESENT;
			end
			ST_PRESENT: begin
				if (r_fire) begin // Beat stays frozen until taken
					r_valid  <= 1'b0;
					cur_addr <= cur_addr + 1'b1;
					beat_cnt <= beat_cnt + 1'b1;
					if (r.last) begin
						ar_ready <= 1'b1;
						state    <= ST_IDLE;
					end else begin
						state    <= ST_FETCH;
					end
				end
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/axi_mem_top.sv
// Burst memory slave with independent read and write paths
// One outstanding burst per direction, no IDs, strobes or wrap bursts
// Same-word read and write in one cycle give an undefined read value
`timescale 1ns/1ps

module axi_mem_top import axi_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// Write address channel
	input  addr_req_t  aw,
	input  logic       aw_valid,
	output logic       aw_ready,
	// Write data channel
	input  w_beat_t    w,
	input  logic       w_valid,
	output logic       w_ready,
	// Write response channel
	output logic [1:0] b_resp,
	output logic       b_valid,
	input  logic       b_ready,
	// Read address channel
	input  addr_req_t  ar,
	input  logic       ar_valid,
	output logic       ar_ready,
	// Read data channel
	output r_beat_t    r,
	output logic       r_valid,
	input  logic       r_ready
);

	mem_wr_t           mem_wr;  // Write controller to memory
	logic              rd_en;   // Read controller to memory
	logic [MEM_AW-1:0] rd_idx;
	logic [DATA_W-1:0] rd_data; // Memory back to read controller

	axi_mem_write_ctrl u_write_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b_resp   (b_resp),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.mem_wr   (mem_wr)
	);

	axi_mem_read_ctrl u_read_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.rd_en    (rd_en),
		.rd_idx   (rd_idx),
		.rd_data  (rd_data)
	);

	mem_array u_mem (
		.clk     (clk),
		.mem_wr  (mem_wr),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

endmodule

//--- hw/axi_mem_write_ctrl.sv
// Write channel controller, one burst at a time, incrementing addresses only
// Beats at or beyond MEM_WORDS are dropped and the burst answers SLVERR
// A last flag that disagrees with len ends the burst with SLVERR
`timescale 1ns/1ps

module axi_mem_write_ctrl import axi_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// Write address channel
	input  addr_req_t  aw,
	input  logic       aw_valid,
	output logic       aw_ready,
	// Write data channel
	input  w_beat_t    w,
	input  logic       w_valid,
	output logic       w_ready,
	// Write response channel
	output logic [1:0] b_resp,
	output logic       b_valid,
	input  logic       b_ready,
	// Memory write port
	output mem_wr_t    mem_wr
);

	typedef enum logic [1:0] {ST_ADDR, ST_DATA, ST_RESP} wr_state_t;

	wr_state_t         state;
	logic [ADDR_W-1:0] cur_addr;  // Word address of the next beat
	logic [LEN_W-1:0]  beat_cnt;  // Beats accepted so far
	logic [LEN_W-1:0]  burst_len; // Beats minus one
	logic              err;       // Sticky burst error
	logic              in_range;
	logic              last_bad;
	logic              beat_err;
	logic              aw_fire;
	logic              w_fire;
	logic              b_fire;

	assign aw_fire  = aw_valid && aw_ready;
	assign w_fire   = w_valid && w_ready;
	assign b_fire   = b_valid && b_ready;

	assign in_range = (cur_addr < ADDR_W'(MEM_WORDS));
	assign last_bad = (w.last != (beat_cnt == burst_len)); // Early or missing last
	assign beat_err = !in_range || last_bad;

	always_ff @(posedge clk) begin
		mem_wr.en <= 1'b0; // Single-cycle write strobe
		if (!rst_n) begin
			state    <= ST_ADDR;
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			b_valid  <= 1'b0;
			err      <= 1'b0;
		end else begin
			case (state)
			ST_ADDR: begin
				if (aw_fire) begin
					cur_addr  <= aw.addr;
					burst_len <= aw.len;
					beat_cnt  <= '0;
					err       <= 1'b0;
					aw_ready  <= 1'b0;
					w_ready   <= 1'b1; // Open data channel next cycle
					state     <= ST_DATA;
				end else begin
					aw_ready  <= 1'b1;
				end
			end
			ST_DATA: begin
				if (w_fire) begin
					mem_wr.en   <= in_range; // Out of range beats are dropped
					mem_wr.idx  <= cur_addr[MEM_AW-1:0];
					mem_wr.data <= w.data;
					cur_addr    <= cur_addr + 1'b1;
					beat_cnt    <= beat_cnt + 1'b1;
					err         <= err || beat_err;
					if (w.last) begin
						w_ready <= 1'b0;
						b_valid <= 1'b1;
						b_resp  <= (err || beat_err) ? RESP_SLVERR : RESP_OKAY;
						state   <= ST_RESP;
					end
				end
			end
			ST_RESP: begin
				if (b_fire) begin // Response held until taken
					b_valid  <= 1'b0;
					aw_ready <= 1'b1;
					state    <= ST_ADDR;
				end
			end
			default: state <= ST_ADDR;
			endcase
		end
	end

endmodule

//--- hw/mem_array.sv
// Simple dual-port word memory, one write and one registered read per cycle
// Contents are undefined until written. No range check here, callers gate it
// Read and write to the same word in one cycle give an undefined read value
`timescale 1ns/1ps

module mem_array import axi_mem_pkg::*; (
	input  logic              clk,
	input  mem_wr_t           mem_wr,  // Write port from the write controller
	input  logic              rd_en,   // Read strobe from the read controller
	input  logic [MEM_AW-1:0] rd_idx,
	output logic [DATA_W-1:0] rd_data  // Valid one cycle after rd_en
);

	// Storage
	logic [DATA_W-1:0] mem [MEM_WORDS];

	// Write side
	always_ff @(posedge clk) begin
		if (mem_wr.en) begin
			mem[mem_wr.idx] <= mem_wr.data;
		end
	end

	// Read side
	// Output register only loads on rd_en
	// so the captured word stays put while the controller waits
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_mem -f flist.f \
	-o tb_axi_mem || { echo "Build failed"; exit 1; }
./obj_dir/tb_axi_mem | tee sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- verification/axi_mem_props.sv
// Handshake rules on the DUT ports, bound into axi_mem_top
// Checks are off while rst_n is low
`timescale 1ns/1ps

module axi_mem_props import axi_mem_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       w_ready,
	input logic [1:0] b_resp,
	input logic       b_valid,
	input logic       b_ready,
	input logic       ar_valid,
	input logic       ar_ready,
	input r_beat_t    r,
	input logic       r_valid,
	input logic       r_ready
);

	// Response stays up and unchanged until taken
	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid && !b_ready |=> b_valid && $stable(b_resp))
		else $error("b channel dropped or changed before b_ready");

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("r beat dropped or changed before r_ready");

	// First beat two cycles after the ar transfer
	r_first: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && ar_ready |=> !r_valid ##1 !r_valid ##1 r_valid)
		else $error("r_valid did not follow the ar transfer by 2 cycles");

	b_after_w: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(b_valid) |-> !w_ready) // Data phase closed first
		else $error("b_valid rose while w_ready was high");

endmodule

//--- verification/tb_axi_mem.sv
// Table-driven testbench for the burst memory, expected words come from a shadow array
// Reads only target words written earlier in the table, other words stay undefined
// Inputs change DRV ns after the rising edge, outputs are sampled while stable
`timescale 1ns/1ps

module tb_axi_mem import axi_mem_pkg::*; ();

	localparam int DRV     = 2;   // Drive delay after rising edge
	localparam int TIMEOUT = 100; // Cycles allowed per wait
	localparam int NUM_OPS = 16;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH} op_kind_t;

	typedef struct {
		op_kind_t    op;
		logic [31:0] addr;    // Start word, write side for OP_BOTH
		logic [31:0] raddr;   // Read start for OP_BOTH
		int          len;     // Beats minus one
		logic [31:0] dseed;   // Mixed into random write data
		bit          b_stall; // Random b_ready back-pressure
		bit          r_stall; // Random r_ready back-pressure
		logic [1:0]  resp;    // b_resp, or worst r.resp of the burst
	} op_t;

	logic              clk = 1'b0;
	logic              rst_n;
	addr_req_t         aw;
	addr_req_t         ar;
	w_beat_t           w;
	r_beat_t           r;
	logic [1:0]        b_resp;
	logic              aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	logic              ar_valid, ar_ready, r_valid, r_ready;
	logic [DATA_W-1:0] shadow [MEM_WORDS]; // Expected memory contents
	integer            seed = 82302;
	int                k;

	op_t tbl [NUM_OPS] = '{
		'{OP_WR,   32'd5,    32'd0,   0,   32'h0000_0000, 1'b0, 1'b0, RESP_OKAY},
		'{OP_WR,   32'd6,    32'd0,   0,   32'h1111_0000, 1'b0, 1'b0, RESP_OKAY},
		'{OP_RD,   32'd5,    32'd0,   0,   32'h0,         1'b0, 1'b0, RESP_OKAY},
		'{OP_RD,   32'd6,    32'd0,   0,   32'h0,         1'b0, 1'b0, RESP_OKAY},
		'{OP_WR,   32'd16,   32'd0,   3,   32'h2222_0000, 1'b0, 1'b0, RESP_OKAY},
		'{OP_RD,   32'd16,   32'd0,   3,   32'h0,         1'b0, 1'b0, RESP_OKAY},
		'{OP_WR,   32'd40,   32'd0,   15,  32'h3333_0000, 1'b1, 1'b0, RESP_OKAY},
		'{OP_RD,   32'd40,   32'd0,   15,  32'h0,         1'b0, 1'b1, RESP_OKAY},
		'{OP_WR,   32'd512,  32'd0,   255, 32'h4444_0000, 1'b0, 1'b0, RESP_OKAY},
		'{OP_RD,   32'd512,  32'd0,   255, 32'h0,         1'b0, 1'b1, RESP_OKAY},
		'{OP_WR,   32'd1020, 32'd0,   7,   32'h5555_0000, 1'b1, 1'b0, RESP_SLVERR}, // Crosses end
		'{OP_RD,   32'd1020, 32'd0,   7,   32'h0,         1'b0, 1'b0, RESP_SLVERR},
		'{OP_WR,   32'd2000, 32'd0,   3,   32'h6666_0000, 1'b0, 1'b0, RESP_SLVERR}, // Beyond end
		'{OP_RD,   32'd2000, 32'd0,   3,   32'h0,         1'b0, 1'b1, RESP_SLVERR},
		'{OP_BOTH, 32'd100,  32'd512, 15,  32'h7777_0000, 1'b1, 1'b1, RESP_OKAY},
		'{OP_RD,   32'd100,  32'd0,   15,  32'h0,         1'b0, 1'b0, RESP_OKAY}
	};

	always #20 clk = ~clk; // 40 ns period

	axi_mem_top UUT (.*);

	bind axi_mem_top axi_mem_props u_props (
		.clk(clk), .rst_n(rst_n), .w_ready(w_ready), .b_resp(b_resp), .b_valid(b_valid),
		.b_ready(b_ready), .ar_valid(ar_valid), .ar_ready(ar_ready), .r(r),
		.r_valid(r_valid), .r_ready(r_ready)
	);

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Mismatch in %s", what);
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout: no %s within %0d cycles, at %0t ns", what, TIMEOUT, $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Handshake timeout");
	endtask

	task automatic write_burst(input op_t t);
		int          i;
		int          cnt;
		int          n;
		logic [31:0] a;
		logic [31:0] data;
		@(posedge clk);
		#DRV;
		aw       = '{addr: t.addr, len: LEN_W'(t.len)};
		aw_valid = 1'b1;
		for (cnt = 0; cnt < TIMEOUT && !aw_ready; cnt++) @(negedge clk);
		if (!aw_ready) timeout_abort("aw_ready");
		@(posedge clk); // aw transfer
		#DRV;
		aw_valid = 1'b0;
		for (i = 0; i <= t.len; i++) begin
			data    = $random(seed) ^ t.dseed;
			a       = t.addr + i;
			w       = '{data: data, last: (i == t.len)};
			w_valid = 1'b1;
			for (cnt = 0; cnt < TIMEOUT && !w_ready; cnt++) @(negedge clk);
			if (!w_ready) timeout_abort("w_ready");
			if (a < MEM_WORDS) shadow[a[MEM_AW-1:0]] = data; // Beyond depth is dropped
			@(posedge clk); // w transfer
			#DRV;
		end
		w_valid = 1'b0;
		for (cnt = 0; cnt < TIMEOUT && !b_valid; cnt++) @(negedge clk);
		if (!b_valid) timeout_abort("b_valid");
		n = t.b_stall ? ($random(seed) & 7) : 0;
		repeat (n + 1) begin // Response must not move while b_ready is low
			check("b channel before b_ready", {b_valid, b_resp}, {1'b1, t.resp});
			@(negedge clk);
		end
		@(posedge clk);
		#DRV;
		b_ready = 1'b1;
		@(posedge clk); // b transfer
		#DRV;
		b_ready = 1'b0;
		check("b_valid after b transfer", b_valid, 1'b0); // Not repeated
	endtask

	task automatic read_burst(input logic [31:0] addr, input int len, input bit stall,
			input logic [1:0] resp);
		int          i;
		int          cnt;
		int          n;
		logic [31:0] a;
		logic [1:0]  worst;
		r_beat_t     exp_beat;
		worst = RESP_OKAY;
		@(posedge clk);
		#DRV;
		ar       = '{addr: addr, len: LEN_W'(len)};
		ar_valid = 1'b1;
		for (cnt = 0; cnt < TIMEOUT && !ar_ready; cnt++) @(negedge clk);
		if (!ar_ready) timeout_abort("ar_ready");
		@(posedge clk); // ar transfer
		#DRV;
		ar_valid = 1'b0;
		for (i = 0; i <= len; i++) begin
			for (cnt = 0; cnt < TIMEOUT && !r_valid; cnt++) @(negedge clk);
			if (!r_valid) timeout_abort("r_valid");
			// Rises on the 2nd rising edge after a transfer, seen at the 3rd falling one
			check("r_valid delay in falling edges", cnt, 3);
			a             = addr + i;
			exp_beat.data = (a < MEM_WORDS) ? shadow[a[MEM_AW-1:0]] : '0;
			exp_beat.resp = (a < MEM_WORDS) ? RESP_OKAY : RESP_SLVERR;
			exp_beat.last = (i == len);
			n = stall ? ($random(seed) & 7) : 0;
			repeat (n + 1) begin // Beat frozen while r_ready is low
				check("r beat", {r_valid, r}, {1'b1, exp_beat});
				@(negedge clk);
			end
			worst = worst | r.resp;
			@(posedge clk);
			#DRV;
			r_ready = 1'b1;
			@(posedge clk); // r transfer
			#DRV;
			r_ready = 1'b0;
		end
		check("r_valid and ar_ready after last beat", {r_valid, ar_ready}, 2'b01);
		check("worst r.resp of burst", worst, resp);
	endtask

	initial begin
		rst_n    = 1'b0;
		aw       = '0;
		aw_valid = 1'b0;
		w        = '0;
		w_valid  = 1'b0;
		b_ready  = 1'b0;
		ar       = '0;
		ar_valid = 1'b0;
		r_ready  = 1'b0;
		repeat (4) begin // 4 reset cycles
			@(posedge clk);
			#DRV;
			check("outputs in reset", {aw_ready, w_ready, b_valid, ar_ready, r_valid}, 5'b0);
		end
		rst_n = 1'b1;
		@(negedge clk);
		check("outputs just after reset", {aw_ready, w_ready, b_valid, ar_ready, r_valid}, 5'b0);
		for (k = 0; k < TIMEOUT && !(aw_ready && ar_ready); k++) @(negedge clk);
		if (!(aw_ready && ar_ready)) timeout_abort("aw_ready and ar_ready after reset");
		for (k = 0; k < NUM_OPS; k++) begin
			case (tbl[k].op)
			OP_WR: write_burst(tbl[k]);
			OP_RD: read_burst(tbl[k].addr, tbl[k].len, tbl[k].r_stall, tbl[k].resp);
			default: begin
				fork // Separate regions, both directions at once
					write_burst(tbl[k]);
					read_burst(tbl[k].raddr, tbl[k].len, tbl[k].r_stall, tbl[k].resp);
				join
			end
			endcase
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
